// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -Wno-fatal -j 0
TOP       ?= bpu_tb
FILELIST  ?= bpu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Simulation passed" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bpu.f
common/bpu_pkg.sv
tage/bimodal_table.sv
tage/tage_bank.sv
tage/tage_predictor.sv
rtl/btb.sv
rtl/ras.sv
rtl/target_select.sv
rtl/bpu.sv
sim/bpu_tb.sv

// File: common/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    localparam int XLEN             = 32;
    localparam int HIST_LEN         = 16;
    localparam int TAG_BITS         = 10;
    localparam int PARTIAL_TAG_BITS = 6;   // upper tag bits checked at lookup
    localparam int BTB_TAG_BITS     = 22;

    // two-bit saturating counter, msb is the direction
    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_STRONG_NT = 2'b00;
    localparam ctr_t CTR_WEAK_NT   = 2'b01;
    localparam ctr_t CTR_WEAK_T    = 2'b10;
    localparam ctr_t CTR_STRONG_T  = 2'b11;

    typedef enum logic [1:0] {
        PROV_BIMODAL = 2'd0,
        PROV_T0      = 2'd1,
        PROV_T1      = 2'd2
    } provider_t;

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam logic [4:0] RA_REG = 5'd1;

    // one step toward the outcome, saturating at both ends
    function automatic ctr_t ctr_step(input ctr_t cur, input logic taken);
        if (taken) begin
            return (cur == CTR_STRONG_T) ? cur : cur + 2'd1;
        end
        return (cur == CTR_STRONG_NT) ? cur : cur - 2'd1;
    endfunction

endpackage

`default_nettype wire

// File: rtl/bpu.sv
`timescale 1ns/1ns
`default_nettype none

module bpu #(
    parameter int BIMODAL_ENTRIES = 512,
    parameter int TAGGED_ENTRIES  = 256,
    parameter int BTB_ENTRIES     = 256,
    parameter int RAS_DEPTH       = 32
) (
    input  wire                              clk,
    input  wire                              rst,
    // fetch
    input  wire  [bpu_pkg::XLEN-1:0]         if_pc_i,
    input  wire  [bpu_pkg::XLEN-1:0]         if_inst_i,
    output logic                             branch_or_not_o,
    output logic                             pdt_res_o,
    output logic [bpu_pkg::XLEN-1:0]         pdt_pc_o,
    output bpu_pkg::provider_t               provider_o,
    output logic [bpu_pkg::HIST_LEN-1:0]     history_o,
    // execute feedback
    input  wire                              ex_branch_valid_i,
    input  wire                              ex_branch_taken_i,
    input  wire                              ex_pdt_true_i,
    input  wire  [bpu_pkg::XLEN-1:0]         ex_pc_i,
    input  wire  [bpu_pkg::XLEN-1:0]         ex_inst_i,
    input  wire  [bpu_pkg::HIST_LEN-1:0]     ex_history_i,
    input  bpu_pkg::provider_t               ex_provider_i,
    input  wire  [bpu_pkg::XLEN-1:0]         ex_target_i,
    // decode push
    input  wire                              id_ras_push_valid_i,
    input  wire  [bpu_pkg::XLEN-1:0]         id_ras_push_data_i,
    input  wire                              ex_stall_valid_i
);

    logic                     tage_taken;
    bpu_pkg::provider_t       tage_provider;
    logic                     btb_hit;
    logic [bpu_pkg::XLEN-1:0] btb_target;
    logic                     ras_empty;
    logic [bpu_pkg::XLEN-1:0] ras_top;

    tage_predictor #(
        .BIMODAL_ENTRIES (BIMODAL_ENTRIES),
        .TAGGED_ENTRIES  (TAGGED_ENTRIES)
    ) tage (
        .clk           (clk),
        .rst           (rst),
        .pc_i          (if_pc_i),
        .taken_o       (tage_taken),
        .provider_o    (tage_provider),
        .ex_valid_i    (ex_branch_valid_i),
        .ex_taken_i    (ex_branch_taken_i),
        .ex_pdt_true_i (ex_pdt_true_i),
        .ex_pc_i       (ex_pc_i),
        .ex_history_i  (ex_history_i),
        .ex_provider_i (ex_provider_i),
        .history_o     (history_o)
    );

    btb #(.ENTRIES(BTB_ENTRIES)) target_buf (
        .clk         (clk),
        .rst         (rst),
        .rd_pc_i     (if_pc_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target),
        .wr_valid_i  (ex_branch_valid_i && ex_branch_taken_i),   // taken only
        .wr_pc_i     (ex_pc_i),
        .wr_target_i (ex_target_i)
    );

    ras #(.DEPTH(RAS_DEPTH)) ret_stack (
        .clk         (clk),
        .rst         (rst),
        .push_i      (id_ras_push_valid_i && !ex_stall_valid_i),
        .push_data_i (id_ras_push_data_i),
        .ex_valid_i  (ex_branch_valid_i),
        .ex_taken_i  (ex_branch_taken_i),
        .ex_inst_i   (ex_inst_i),
        .empty_o     (ras_empty),
        .top_o       (ras_top)
    );

    target_select sel (
        .pc_i            (if_pc_i),
        .inst_i          (if_inst_i),
        .tage_taken_i    (tage_taken),
        .tage_provider_i (tage_provider),
        .btb_hit_i       (btb_hit),
        .btb_target_i    (btb_target),
        .ras_empty_i     (ras_empty),
        .ras_top_i       (ras_top),
        .branch_or_not_o (branch_or_not_o),
        .pdt_res_o       (pdt_res_o),
        .pdt_pc_o        (pdt_pc_o),
        .provider_o      (provider_o)
    );

endmodule

`default_nettype wire

// File: rtl/btb.sv
`timescale 1ns/1ns
`default_nettype none

module btb #(
    parameter int ENTRIES = 256
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire  [bpu_pkg::XLEN-1:0]     rd_pc_i,
    output logic                         hit_o,
    output logic [bpu_pkg::XLEN-1:0]     target_o,
    input  wire                          wr_valid_i,
    input  wire  [bpu_pkg::XLEN-1:0]     wr_pc_i,
    input  wire  [bpu_pkg::XLEN-1:0]     wr_target_i
);

    localparam int IDX_W = $clog2(ENTRIES);
    localparam int TW    = bpu_pkg::BTB_TAG_BITS;

    logic                     valid  [ENTRIES];
    logic [TW-1:0]            tag    [ENTRIES];
    logic [bpu_pkg::XLEN-1:0] target [ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign rd_idx = rd_pc_i[IDX_W+1:2];   // word index
    assign wr_idx = wr_pc_i[IDX_W+1:2];

    assign hit_o    = valid[rd_idx] && (tag[rd_idx] == rd_pc_i[bpu_pkg::XLEN-1 -: TW]);
    assign target_o = target[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (wr_valid_i) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid_i) begin
            tag[wr_idx]    <= wr_pc_i[bpu_pkg::XLEN-1 -: TW];
            target[wr_idx] <= wr_target_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/ras.sv
`timescale 1ns/1ns
`default_nettype none

module ras #(
    parameter int DEPTH = 32
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          push_i,
    input  wire  [bpu_pkg::XLEN-1:0]     push_data_i,
    input  wire                          ex_valid_i,
    input  wire                          ex_taken_i,
    input  wire  [bpu_pkg::XLEN-1:0]     ex_inst_i,
    output logic                         empty_o,
    output logic [bpu_pkg::XLEN-1:0]     top_o
);

    localparam int ADDR_W = $clog2(DEPTH);

    logic [bpu_pkg::XLEN-1:0] stack [DEPTH];
    logic [ADDR_W:0]          sp;      // count of live entries
    logic [ADDR_W-1:0]        top_idx;
    logic                     full;
    logic                     ret_exec;
    logic                     pop;

    assign top_idx = sp[ADDR_W-1:0] - ADDR_W'(1);
    assign empty_o = (sp == '0);
    assign full    = (sp == (ADDR_W+1)'(DEPTH));
    assign top_o   = stack[top_idx];

    // executed return, jalr through ra
    assign ret_exec = ex_valid_i && ex_taken_i
                   && (ex_inst_i[6:0] == bpu_pkg::OPC_JALR)
                   && (ex_inst_i[19:15] == bpu_pkg::RA_REG);
    assign pop = ret_exec && !empty_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp <= '0;
        end else if (pop && !push_i) begin
            sp <= sp - 1'b1;
        end else if (push_i && !pop && !full) begin
            sp <= sp + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i && pop) begin
            stack[top_idx] <= push_data_i;   // replace top, depth unchanged
        end else if (push_i && !full) begin
            stack[sp[ADDR_W-1:0]] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/target_select.sv
`timescale 1ns/1ns
`default_nettype none

module target_select (
    input  wire  [bpu_pkg::XLEN-1:0]     pc_i,
    input  wire  [bpu_pkg::XLEN-1:0]     inst_i,
    input  wire                          tage_taken_i,
    input  bpu_pkg::provider_t           tage_provider_i,
    input  wire                          btb_hit_i,
    input  wire  [bpu_pkg::XLEN-1:0]     btb_target_i,
    input  wire                          ras_empty_i,
    input  wire  [bpu_pkg::XLEN-1:0]     ras_top_i,
    output logic                         branch_or_not_o,
    output logic                         pdt_res_o,
    output logic [bpu_pkg::XLEN-1:0]     pdt_pc_o,
    output bpu_pkg::provider_t           provider_o
);

    logic is_branch, is_jal, is_jalr, is_ret;
    logic [bpu_pkg::XLEN-1:0] pc_plus4;
    logic [bpu_pkg::XLEN-1:0] b_imm;
    logic [bpu_pkg::XLEN-1:0] j_imm;

    assign is_branch = (inst_i[6:0] == bpu_pkg::OPC_BRANCH);
    assign is_jal    = (inst_i[6:0] == bpu_pkg::OPC_JAL);
    assign is_jalr   = (inst_i[6:0] == bpu_pkg::OPC_JALR);
    assign is_ret    = is_jalr && (inst_i[11:7] == 5'd0)
                    && (inst_i[19:15] == bpu_pkg::RA_REG)
                    && (inst_i[31:20] == 12'd0);

    assign pc_plus4 = pc_i + 32'd4;
    assign b_imm = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign j_imm = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    assign provider_o = tage_provider_i;

    always_comb begin
        branch_or_not_o = 1'b0;
        pdt_res_o       = 1'b0;
        pdt_pc_o        = pc_plus4;
        if (is_ret) begin
            branch_or_not_o = 1'b1;
            if (!ras_empty_i) begin
                pdt_res_o = 1'b1;
                pdt_pc_o  = ras_top_i;
            end else if (btb_hit_i) begin
                pdt_res_o = 1'b1;
                pdt_pc_o  = btb_target_i;
            end            // nothing known, fall through
        end else if (is_jal) begin
            branch_or_not_o = 1'b1;
            pdt_res_o       = 1'b1;
            pdt_pc_o        = btb_hit_i ? btb_target_i : pc_i + j_imm;
        end else if (is_branch || is_jalr) begin
            branch_or_not_o = 1'b1;
            pdt_res_o       = tage_taken_i;
            if (tage_taken_i) begin
                if (btb_hit_i) begin
                    pdt_pc_o = btb_target_i;
                end else if (is_branch) begin
                    pdt_pc_o = pc_i + b_imm;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/bpu_stimulus.txt
# L pc inst exp_branch exp_taken exp_next_pc exp_provider / F pc inst taken pdt_true provider target
# P data push / S data push under stall / R count random lookups / I idle, addresses in hex
R 20
# jal ra,256 then retargeted through the btb
L 00001000 100000ef 1 1 00001100 0
F 00001000 100000ef 1 1 0 00002000
L 00001000 100000ef 1 1 00002000 0
I
L 00001000 100000ef 1 1 00002000 0
# beq trained through an aliasing pc so the btb holds no entry for it
L 00003010 00000863 1 0 00003014 0
F 00403010 00000863 1 1 0 00403020
F 00403010 00000863 1 1 0 00403020
L 00003010 00000863 1 1 00003020 0
# bimodal miss allocates into t1
L 00005020 00000863 1 0 00005024 0
F 00005020 00000863 1 0 0 00005030
L 00005020 00000863 1 1 00005030 2
# return stack
P 00000104
P 00000208
L 00006000 00008067 1 1 00000208 0
F 00007004 00008067 1 1 0 00000208
L 00006000 00008067 1 1 00000104 0
S 0000030c
L 00006000 00008067 1 1 00000104 0
F 00007004 00008067 1 1 0 00000104
L 00006000 00008067 1 0 00006004 0

// File: sim/bpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module bpu_tb;

    localparam int XLEN          = bpu_pkg::XLEN;
    localparam int HL            = bpu_pkg::HIST_LEN;
    localparam int RESET_CYCLES  = 4;
    localparam int CYCLES_PER_OP = 20;   // watchdog budget per stimulus line or random lookup

    logic               clk;
    logic               rst;
    logic [XLEN-1:0]    if_pc;
    logic [XLEN-1:0]    if_inst;
    logic               branch_or_not;
    logic               pdt_res;
    logic [XLEN-1:0]    pdt_pc;
    bpu_pkg::provider_t provider;
    logic [HL-1:0]      history;
    logic               ex_branch_valid;
    logic               ex_branch_taken;
    logic               ex_pdt_true;
    logic [XLEN-1:0]    ex_pc;
    logic [XLEN-1:0]    ex_inst;
    logic [HL-1:0]      ex_history;
    bpu_pkg::provider_t ex_provider;
    logic [XLEN-1:0]    ex_target;
    logic               id_ras_push_valid;
    logic [XLEN-1:0]    id_ras_push_data;
    logic               ex_stall_valid;

    string         lines[$];
    logic [HL-1:0] hist_model;           // expected global history
    logic [31:0]   rng_state;
    int            n_lookups;
    int            wd_cycles;

    bpu dut_i (
        .clk                 (clk),
        .rst                 (rst),
        .if_pc_i             (if_pc),
        .if_inst_i           (if_inst),
        .branch_or_not_o     (branch_or_not),
        .pdt_res_o           (pdt_res),
        .pdt_pc_o            (pdt_pc),
        .provider_o          (provider),
        .history_o           (history),
        .ex_branch_valid_i   (ex_branch_valid),
        .ex_branch_taken_i   (ex_branch_taken),
        .ex_pdt_true_i       (ex_pdt_true),
        .ex_pc_i             (ex_pc),
        .ex_inst_i           (ex_inst),
        .ex_history_i        (ex_history),
        .ex_provider_i       (ex_provider),
        .ex_target_i         (ex_target),
        .id_ras_push_valid_i (id_ras_push_valid),
        .id_ras_push_data_i  (id_ras_push_data),
        .ex_stall_valid_i    (ex_stall_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string what);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t ns: %s expected %h, got %h",
                                     $time, what, exp, got));
        end
    endtask

    task automatic check_provider(input bpu_pkg::provider_t got,
                                  input bpu_pkg::provider_t exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t ns: provider expected %0d, got %0d",
                                     $time, exp, got));
        end
    endtask

    task automatic check_history(input logic [HL-1:0] got, input logic [HL-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t ns: history expected %h, got %h",
                                     $time, exp, got));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // any opcode except branch, jal and jalr
    function automatic logic [XLEN-1:0] non_control_word(input logic [31:0] r);
        logic [XLEN-1:0] w;
        w = r;
        if (w[6:0] == bpu_pkg::OPC_BRANCH || w[6:0] == bpu_pkg::OPC_JAL
                || w[6:0] == bpu_pkg::OPC_JALR) begin
            w[6:0] = 7'b0010011;   // op-imm
        end
        return w;
    endfunction

    // one slot per operation with inputs changing 1 ns after the edge
    task automatic next_slot();
        @(posedge clk);
        #1;
        ex_branch_valid   = 1'b0;
        id_ras_push_valid = 1'b0;
        ex_stall_valid    = 1'b0;
    endtask

    task automatic do_lookup(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] inst,
                             input logic exp_br, input logic exp_res,
                             input logic [XLEN-1:0] exp_pc, input bpu_pkg::provider_t exp_prov);
        next_slot();
        if_pc   = pc;
        if_inst = inst;
        #4;                                // outputs settled well before the next edge
        check_word(XLEN'(branch_or_not), XLEN'(exp_br), "branch_or_not");
        check_word(XLEN'(pdt_res), XLEN'(exp_res), "pdt_res");
        check_word(pdt_pc, exp_pc, "pdt_pc");
        check_provider(provider, exp_prov);
        check_history(history, hist_model);
        n_lookups++;
    endtask

    task automatic do_feedback(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] inst,
                               input logic taken, input logic pdt_true,
                               input bpu_pkg::provider_t prov, input logic [XLEN-1:0] target);
        next_slot();
        ex_branch_valid = 1'b1;
        ex_branch_taken = taken;
        ex_pdt_true     = pdt_true;
        ex_pc           = pc;
        ex_inst         = inst;
        ex_provider     = prov;
        ex_target       = target;
        ex_history      = {hist_model[HL-2:0], taken};   // history after this shift
        hist_model      = ex_history;
    endtask

    // a not-taken branch outcome has to shift a zero into the history
    task automatic shift_not_taken();
        do_feedback(32'h0000_9000, 32'h0000_0863, 1'b0, 1'b1, bpu_pkg::PROV_BIMODAL,
                    32'h0000_9004);
        next_slot();
        #4;
        check_history(history, hist_model);
    endtask

    task automatic do_push(input logic [XLEN-1:0] data, input logic stall);
        next_slot();
        id_ras_push_valid = 1'b1;
        id_ras_push_data  = data;
        ex_stall_valid    = stall;
    endtask

    task automatic random_lookups(input int count);
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
        for (int i = 0; i < count; i++) begin
            rng_state = xorshift(rng_state);
            pc        = {rng_state[31:2], 2'b00};
            rng_state = xorshift(rng_state);
            inst      = non_control_word(rng_state);
            do_lookup(pc, inst, 1'b0, 1'b0, pc + 32'd4, bpu_pkg::PROV_BIMODAL);
        end
    endtask

    task automatic load_stimulus();
        int    fd;
        string line;
        fd = $fopen("sim/bpu_stimulus.txt", "r");
        if (fd == 0) begin
            report_failure("could not open the stimulus file sim/bpu_stimulus.txt");
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0) begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        string           rest;
        byte             op;
        int              cnt;
        int              n_random;
        int              flag_a;
        int              flag_b;
        int              prov;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] val;

        rst               = 1'b1;
        if_pc             = '0;
        if_inst           = '0;
        ex_branch_valid   = 1'b0;
        ex_branch_taken   = 1'b0;
        ex_pdt_true       = 1'b0;
        ex_pc             = '0;
        ex_inst           = '0;
        ex_history        = '0;
        ex_provider       = bpu_pkg::PROV_BIMODAL;
        ex_target         = '0;
        id_ras_push_valid = 1'b0;
        id_ras_push_data  = '0;
        ex_stall_valid    = 1'b0;
        hist_model        = '0;
        rng_state         = 32'd96345;
        n_lookups         = 0;
        n_random          = 0;

        load_stimulus();
        foreach (lines[i]) begin
            if (lines[i].len() > 1 && lines[i].getc(0) == "R") begin
                if ($sscanf(lines[i].substr(1, lines[i].len() - 1), "%d", cnt) == 1) begin
                    n_random += cnt;
                end
            end
        end
        wd_cycles = RESET_CYCLES + (lines.size() + n_random) * CYCLES_PER_OP;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        foreach (lines[i]) begin
            if (lines[i].len() == 0) begin
                continue;
            end
            op   = lines[i].getc(0);
            rest = (lines[i].len() > 1) ? lines[i].substr(1, lines[i].len() - 1) : "";
            if (op == "#" || op == "\n" || op == "\r" || op == " ") begin
                continue;
            end
            case (op)
                "L": begin
                    cnt = $sscanf(rest, "%h %h %d %d %h %d", pc, inst, flag_a, flag_b, val, prov);
                    if (cnt != 6) begin
                        report_failure($sformatf("stimulus line %0d is not a valid lookup", i + 1));
                    end
                    do_lookup(pc, inst, flag_a[0], flag_b[0], val,
                              bpu_pkg::provider_t'(prov[1:0]));
                end
                "F": begin
                    cnt = $sscanf(rest, "%h %h %d %d %d %h", pc, inst, flag_a, flag_b, prov, val);
                    if (cnt != 6) begin
                        report_failure($sformatf("stimulus line %0d is not a valid feedback",
                                                 i + 1));
                    end
                    do_feedback(pc, inst, flag_a[0], flag_b[0],
                                bpu_pkg::provider_t'(prov[1:0]), val);
                end
                "P", "S": begin
                    if ($sscanf(rest, "%h", val) != 1) begin
                        report_failure($sformatf("stimulus line %0d is not a valid push", i + 1));
                    end
                    do_push(val, op == "S");
                end
                "R": begin
                    if ($sscanf(rest, "%d", cnt) != 1) begin
                        report_failure($sformatf("stimulus line %0d has no lookup count", i + 1));
                    end
                    random_lookups(cnt);
                end
                "I": next_slot();
                default: begin
                    report_failure($sformatf("unknown operation on stimulus line %0d", i + 1));
                end
            endcase
        end

        shift_not_taken();

        next_slot();
        if (n_lookups > 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            report_failure("the stimulus file held no lookup to check");
        end
    end

    // watchdog armed once the stimulus length is known
    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        report_failure($sformatf("timeout, the stimulus did not finish within %0d cycles",
                                 wd_cycles));
    end

endmodule

`default_nettype wire

// File: tage/bimodal_table.sv
`timescale 1ns/1ns
`default_nettype none

module bimodal_table #(
    parameter int ENTRIES = 512
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire  [bpu_pkg::XLEN-1:0]     rd_pc_i,
    output logic                         rd_taken_o,
    input  wire                          upd_valid_i,
    input  wire                          upd_taken_i,
    input  wire  [bpu_pkg::XLEN-1:0]     upd_pc_i
);

    localparam int IDX_W = $clog2(ENTRIES);

    bpu_pkg::ctr_t ctr [ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] upd_idx;

    assign rd_idx  = rd_pc_i[IDX_W:1];   // skip bit 0 only
    assign upd_idx = upd_pc_i[IDX_W:1];

    assign rd_taken_o = ctr[rd_idx][1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr[i] <= bpu_pkg::CTR_WEAK_NT;
            end
        end else if (upd_valid_i) begin
            ctr[upd_idx] <= bpu_pkg::ctr_step(ctr[upd_idx], upd_taken_i);
        end
    end

endmodule

`default_nettype wire

// File: tage/tage_bank.sv
`timescale 1ns/1ns
`default_nettype none

module tage_bank #(
    parameter int ENTRIES = 256,
    parameter int HIST_LO = 0            // low end of the index history slice
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire  [bpu_pkg::XLEN-1:0]         rd_pc_i,
    input  wire  [bpu_pkg::HIST_LEN-1:0]     rd_hist_i,
    output logic                             rd_match_o,
    output logic                             rd_taken_o,
    input  wire  [bpu_pkg::XLEN-1:0]         upd_pc_i,
    input  wire  [bpu_pkg::HIST_LEN-1:0]     upd_hist_i,
    input  wire                              upd_taken_i,
    input  wire                              upd_train_i,
    input  wire                              upd_reset_i,
    input  wire                              upd_alloc_i,
    output logic                             upd_tag_hit_o
);

    localparam int IDX_W = $clog2(ENTRIES);
    localparam int TW    = bpu_pkg::TAG_BITS;
    localparam int PW    = bpu_pkg::PARTIAL_TAG_BITS;

    logic          valid [ENTRIES];
    logic [TW-1:0] tag   [ENTRIES];
    bpu_pkg::ctr_t ctr   [ENTRIES];

    function automatic logic [TW-1:0] tag_of(input logic [bpu_pkg::XLEN-1:0] pc,
                                             input logic [bpu_pkg::HIST_LEN-1:0] hist);
        logic [TW-1:0] fold;
        // short bank folds the upper history, long bank the lower byte
        if (HIST_LO == 0) begin
            fold = hist[bpu_pkg::HIST_LEN-1 -: TW];
        end else begin
            fold = TW'(hist[7:0]);
        end
        return pc[8 +: TW] ^ fold;
    endfunction

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] upd_idx;
    logic [TW-1:0]    rd_tag;
    logic [TW-1:0]    upd_tag;

    assign rd_idx  = rd_pc_i[IDX_W-1:0] ^ rd_hist_i[HIST_LO +: IDX_W];
    assign upd_idx = upd_pc_i[IDX_W-1:0] ^ upd_hist_i[HIST_LO +: IDX_W];
    assign rd_tag  = tag_of(rd_pc_i, rd_hist_i);
    assign upd_tag = tag_of(upd_pc_i, upd_hist_i);

    assign rd_match_o = valid[rd_idx] && (tag[rd_idx][TW-1 -: PW] == rd_tag[TW-1 -: PW]);
    assign rd_taken_o = ctr[rd_idx][1];

    assign upd_tag_hit_o = valid[upd_idx] && (tag[upd_idx] == upd_tag);  // full tag here

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (upd_alloc_i) begin
            valid[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_alloc_i) begin
            tag[upd_idx] <= upd_tag;
            ctr[upd_idx] <= upd_taken_i ? bpu_pkg::CTR_WEAK_T : bpu_pkg::CTR_WEAK_NT;
        end else if (upd_reset_i) begin
            ctr[upd_idx] <= upd_taken_i ? bpu_pkg::CTR_STRONG_T : bpu_pkg::CTR_STRONG_NT;
        end else if (upd_train_i) begin
            ctr[upd_idx] <= bpu_pkg::ctr_step(ctr[upd_idx], upd_taken_i);
        end
    end

endmodule

`default_nettype wire

// File: tage/tage_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module tage_predictor #(
    parameter int BIMODAL_ENTRIES = 512,
    parameter int TAGGED_ENTRIES  = 256
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire  [bpu_pkg::XLEN-1:0]         pc_i,
    output logic                             taken_o,
    output bpu_pkg::provider_t               provider_o,
    input  wire                              ex_valid_i,
    input  wire                              ex_taken_i,
    input  wire                              ex_pdt_true_i,
    input  wire  [bpu_pkg::XLEN-1:0]         ex_pc_i,
    input  wire  [bpu_pkg::HIST_LEN-1:0]     ex_history_i,
    input  bpu_pkg::provider_t               ex_provider_i,
    output logic [bpu_pkg::HIST_LEN-1:0]     history_o
);

    logic [bpu_pkg::HIST_LEN-1:0] ghist;

    logic bm_taken;
    logic t0_match, t0_taken, t0_tag_hit;
    logic t1_match, t1_taken, t1_tag_hit;
    logic t0_train, t0_reset, t0_alloc;
    logic t1_train, t1_reset, t1_alloc;
    logic miss_bm;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
        end else if (ex_valid_i) begin
            ghist <= {ghist[bpu_pkg::HIST_LEN-2:0], ex_taken_i};
        end
    end

    assign history_o = ghist;

    // longest history wins
    always_comb begin
        if (t1_match) begin
            provider_o = bpu_pkg::PROV_T1;
            taken_o    = t1_taken;
        end else if (t0_match) begin
            provider_o = bpu_pkg::PROV_T0;
            taken_o    = t0_taken;
        end else begin
            provider_o = bpu_pkg::PROV_BIMODAL;
            taken_o    = bm_taken;
        end
    end

    // feedback routing
    assign t1_train = ex_valid_i && ex_pdt_true_i && (ex_provider_i == bpu_pkg::PROV_T1);
    assign t0_train = ex_valid_i && ex_pdt_true_i && (ex_provider_i == bpu_pkg::PROV_T0);
    assign t1_reset = ex_valid_i && !ex_pdt_true_i && (ex_provider_i == bpu_pkg::PROV_T1);
    assign t0_reset = ex_valid_i && !ex_pdt_true_i && (ex_provider_i == bpu_pkg::PROV_T0);
    assign miss_bm  = ex_valid_i && !ex_pdt_true_i && (ex_provider_i == bpu_pkg::PROV_BIMODAL);
    assign t1_alloc = miss_bm && !t1_tag_hit;
    assign t0_alloc = miss_bm && t1_tag_hit && !t0_tag_hit;   // fall back to the short bank

    bimodal_table #(.ENTRIES(BIMODAL_ENTRIES)) bimodal (
        .clk         (clk),
        .rst         (rst),
        .rd_pc_i     (pc_i),
        .rd_taken_o  (bm_taken),
        .upd_valid_i (ex_valid_i),
        .upd_taken_i (ex_taken_i),
        .upd_pc_i    (ex_pc_i)
    );

    tage_bank #(.ENTRIES(TAGGED_ENTRIES), .HIST_LO(0)) t0_bank (
        .clk           (clk),
        .rst           (rst),
        .rd_pc_i       (pc_i),
        .rd_hist_i     (ghist),
        .rd_match_o    (t0_match),
        .rd_taken_o    (t0_taken),
        .upd_pc_i      (ex_pc_i),
        .upd_hist_i    (ex_history_i),
        .upd_taken_i   (ex_taken_i),
        .upd_train_i   (t0_train),
        .upd_reset_i   (t0_reset),
        .upd_alloc_i   (t0_alloc),
        .upd_tag_hit_o (t0_tag_hit)
    );

    tage_bank #(.ENTRIES(TAGGED_ENTRIES), .HIST_LO(8)) t1_bank (
        .clk           (clk),
        .rst           (rst),
        .rd_pc_i       (pc_i),
        .rd_hist_i     (ghist),
        .rd_match_o    (t1_match),
        .rd_taken_o    (t1_taken),
        .upd_pc_i      (ex_pc_i),
        .upd_hist_i    (ex_history_i),
        .upd_taken_i   (ex_taken_i),
        .upd_train_i   (t1_train),
        .upd_reset_i   (t1_reset),
        .upd_alloc_i   (t1_alloc),
        .upd_tag_hit_o (t1_tag_hit)
    );

endmodule

`default_nettype wire
